// ==== rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// register file
`define RV_REG_COUNT 32
`define RV_REG_AW 5

// unified RAM, word addressed
`define RV_MEM_WORDS 1024
`define RV_MEM_AW 10

// first fetch address
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== hw/rv_pkg.sv ====
`include "rv_params.svh"

package rv_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SRL  = 4'd3,
        ALU_SRA  = 4'd4,
        ALU_AND  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_PASS = 4'd10 // lui, passes operand b
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } branch_t;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2
    } wb_sel_t;

    typedef struct packed {
        alu_op_t alu_op;
        branch_t branch;
        logic    use_imm;   // operand b is the immediate
        logic    use_pc;    // operand a is the pc
        logic    jump;
        logic    jump_reg;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_byte;
        wb_sel_t wb_sel;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_fields_t;

    // same word seen raw (immediates) or split into fields
    typedef union packed {
        logic [31:0]  raw;
        inst_fields_t f;
    } inst_t;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [`RV_MEM_AW-1:0] addr; // word address
        logic [3:0]            be;
        logic [31:0]           wdata;
    } mem_req_t;

endpackage

// ==== hw/inst_decoder.sv ====
module inst_decoder (
    input  rv_pkg::inst_t inst,
    output rv_pkg::ctrl_t ctrl,
    output logic [31:0]   imm
);

    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign imm_i = {{20{inst.raw[31]}}, inst.raw[31:20]};
    assign imm_s = {{20{inst.raw[31]}}, inst.raw[31:25], inst.raw[11:7]};
    assign imm_b = {{19{inst.raw[31]}}, inst.raw[31], inst.raw[7], inst.raw[30:25],
                    inst.raw[11:8], 1'b0};
    assign imm_u = {inst.raw[31:12], 12'b0};
    assign imm_j = {{11{inst.raw[31]}}, inst.raw[31], inst.raw[19:12], inst.raw[20],
                    inst.raw[30:21], 1'b0};

    // alt picks sub over add and sra over srl
    function automatic rv_pkg::alu_op_t alu_sel(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'd0:    return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'd1:    return rv_pkg::ALU_SLL;
            3'd2:    return rv_pkg::ALU_SLT;
            3'd3:    return rv_pkg::ALU_SLTU;
            3'd4:    return rv_pkg::ALU_XOR;
            3'd5:    return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'd6:    return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (inst.f.opcode)
            7'b0110011: begin // register-register
                ctrl.alu_op    = alu_sel(inst.f.funct3, inst.f.funct7[5]);
                ctrl.reg_write = 1'b1;
            end
            7'b0010011: begin
                ctrl.alu_op    = alu_sel(inst.f.funct3,
                                         inst.f.funct3 == 3'd5 && inst.f.funct7[5]);
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_i;
            end
            7'b0000011: begin
                if (inst.f.funct3 == 3'd0 || inst.f.funct3 == 3'd2) begin
                    ctrl.use_imm   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.mem_byte  = inst.f.funct3 == 3'd0; // lb
                    ctrl.wb_sel    = rv_pkg::WB_MEM;
                    imm            = imm_i;
                end
            end
            7'b0100011: begin
                if (inst.f.funct3 == 3'd0 || inst.f.funct3 == 3'd2) begin
                    ctrl.use_imm   = 1'b1;
                    ctrl.mem_write = 1'b1;
                    ctrl.mem_byte  = inst.f.funct3 == 3'd0; // sb
                    imm            = imm_s;
                end
            end
            7'b1100011: begin
                case (inst.f.funct3)
                    3'd0:    ctrl.branch = rv_pkg::BR_EQ;
                    3'd1:    ctrl.branch = rv_pkg::BR_NE;
                    3'd4:    ctrl.branch = rv_pkg::BR_LT;
                    3'd5:    ctrl.branch = rv_pkg::BR_GE;
                    3'd6:    ctrl.branch = rv_pkg::BR_LTU;
                    3'd7:    ctrl.branch = rv_pkg::BR_GEU;
                    default: ctrl.branch = rv_pkg::BR_NONE;
                endcase
                imm = imm_b;
            end
            7'b1101111: begin // jal
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::WB_LINK;
                imm            = imm_j;
            end
            7'b1100111: begin // jalr, target through the alu
                ctrl.jump_reg  = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::WB_LINK;
                imm            = imm_i;
            end
            7'b0110111: begin // lui
                ctrl.alu_op    = rv_pkg::ALU_PASS;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_u;
            end
            7'b0010111: begin // auipc
                ctrl.use_pc    = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_u;
            end
            7'b1110011: ctrl.halt = inst.raw == 32'h0010_0073; // ebreak only
            default: ;
        endcase
    end

endmodule

// ==== hw/alu.sv ====
`include "rv_params.svh"

module alu (
    input  rv_pkg::alu_op_t     op,
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    output logic [`RV_XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:  result = a + b;
            rv_pkg::ALU_SUB:  result = a - b;
            rv_pkg::ALU_SLL:  result = a << shamt;
            rv_pkg::ALU_SRL:  result = a >> shamt;
            rv_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
            rv_pkg::ALU_AND:  result = a & b;
            rv_pkg::ALU_OR:   result = a | b;
            rv_pkg::ALU_XOR:  result = a ^ b;
            rv_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU: result = {31'b0, a < b};
            rv_pkg::ALU_PASS: result = b;
            default:          result = '0;
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
`include "rv_params.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`RV_REG_AW-1:0]  rs1_addr,
    input  logic [`RV_REG_AW-1:0]  rs2_addr,
    output logic [`RV_XLEN-1:0]    rs1_data,
    output logic [`RV_XLEN-1:0]    rs2_data,
    input  logic [`RV_REG_AW-1:0]  rd_addr,
    input  logic                   rd_write,
    input  logic [`RV_XLEN-1:0]    rd_data
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_write && rd_addr != '0) begin // x0 stays zero
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== hw/cpu_core.sv ====
`include "rv_params.svh"

module cpu_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    output rv_pkg::mem_req_t    mem_req,
    input  logic                mem_gnt,
    input  logic [`RV_XLEN-1:0] mem_rdata,
    output logic                halted
);

    typedef enum logic [1:0] {FETCH, EXECUTE, MEMORY} state_t;

    state_t              state;
    logic [`RV_XLEN-1:0] pc, pc_plus4, pc_imm, pc_next;
    logic [31:0]         inst_q;
    rv_pkg::inst_t       cur_inst;
    rv_pkg::ctrl_t       ctrl;
    logic [31:0]         imm;
    logic [`RV_XLEN-1:0] rs1_data, rs2_data, op_a, op_b, alu_res, rd_data, load_byte;
    logic                take_branch, rd_write;

    // instruction arrives straight from memory in EXECUTE, held for MEMORY
    assign cur_inst = (state == EXECUTE) ? mem_rdata : inst_q;

    inst_decoder u_dec (.inst(cur_inst), .ctrl(ctrl), .imm(imm));

    reg_file u_rf (
        .clk(clk), .reset(reset),
        .rs1_addr(cur_inst.f.rs1), .rs2_addr(cur_inst.f.rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rd_addr(cur_inst.f.rd), .rd_write(rd_write), .rd_data(rd_data)
    );

    assign op_a = ctrl.use_pc ? pc : rs1_data;
    assign op_b = ctrl.use_imm ? imm : rs2_data;

    alu u_alu (.op(ctrl.alu_op), .a(op_a), .b(op_b), .result(alu_res));

    assign pc_plus4 = pc + 32'd4;
    assign pc_imm   = pc + imm;

    always_comb begin
        case (ctrl.branch)
            rv_pkg::BR_EQ:  take_branch = rs1_data == rs2_data;
            rv_pkg::BR_NE:  take_branch = rs1_data != rs2_data;
            rv_pkg::BR_LT:  take_branch = $signed(rs1_data) < $signed(rs2_data);
            rv_pkg::BR_GE:  take_branch = $signed(rs1_data) >= $signed(rs2_data);
            rv_pkg::BR_LTU: take_branch = rs1_data < rs2_data;
            rv_pkg::BR_GEU: take_branch = rs1_data >= rs2_data;
            default:        take_branch = 1'b0;
        endcase
        pc_next = pc_plus4;
        if (ctrl.jump || take_branch)
            pc_next = pc_imm;
        else if (ctrl.jump_reg)
            pc_next = {alu_res[31:1], 1'b0};
    end

    assign load_byte = {{24{mem_rdata[{alu_res[1:0], 3'b000} + 7]}},
                        mem_rdata[{alu_res[1:0], 3'b000} +: 8]};

    always_comb begin
        case (ctrl.wb_sel)
            rv_pkg::WB_MEM:  rd_data = ctrl.mem_byte ? load_byte : mem_rdata;
            rv_pkg::WB_LINK: rd_data = pc_plus4;
            default:         rd_data = alu_res;
        endcase
    end

    // loads write back in MEMORY, everything else in EXECUTE
    assign rd_write = ctrl.reg_write &&
                      ((state == EXECUTE && !ctrl.mem_read) || (state == MEMORY && ctrl.mem_read));

    always_comb begin
        mem_req = '0;
        if (state == FETCH && run && !halted) begin
            mem_req.valid = 1'b1;
            mem_req.addr  = pc[`RV_MEM_AW+1:2];
        end else if (state == EXECUTE && (ctrl.mem_read || ctrl.mem_write)) begin
            mem_req.valid = 1'b1;
            mem_req.write = ctrl.mem_write;
            mem_req.addr  = alu_res[`RV_MEM_AW+1:2];
            mem_req.be    = ctrl.mem_byte ? 4'b0001 << alu_res[1:0] : 4'b1111;
            mem_req.wdata = ctrl.mem_byte ? {4{rs2_data[7:0]}} : rs2_data; // byte on every lane
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state  <= FETCH;
            pc     <= `RV_RESET_PC;
            halted <= 1'b0;
        end else begin
            case (state)
                FETCH: if (mem_req.valid && mem_gnt) state <= EXECUTE;
                EXECUTE: begin
                    pc     <= pc_next;
                    halted <= halted | ctrl.halt;
                    state  <= (ctrl.mem_read || ctrl.mem_write) ? MEMORY : FETCH;
                end
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXECUTE)
            inst_q <= mem_rdata;
    end

endmodule

// ==== hw/mem_arbiter.sv ====
`include "rv_params.svh"

module mem_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  rv_pkg::mem_req_t    core_req,
    output logic                core_gnt,
    output logic [`RV_XLEN-1:0] core_rdata,
    input  rv_pkg::mem_req_t    host_req,
    output logic                host_gnt,
    output logic [`RV_XLEN-1:0] host_rdata,
    output rv_pkg::mem_req_t    ram_req,
    input  logic [`RV_XLEN-1:0] ram_rdata
);

    logic host_sel; // who owns the read data this cycle

    // core has fixed priority, host only takes idle cycles
    assign core_gnt = core_req.valid;
    assign host_gnt = host_req.valid && !core_req.valid;

    assign ram_req = core_req.valid ? core_req : host_req;

    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            host_sel <= 1'b0;
        else if (core_gnt || host_gnt)
            host_sel <= host_gnt;
    end

    assign core_rdata = host_sel ? '0 : ram_rdata;
    assign host_rdata = host_sel ? ram_rdata : '0;

endmodule

// ==== hw/unified_ram.sv ====
`include "rv_params.svh"

module unified_ram (
    input  logic                clk,
    input  rv_pkg::mem_req_t    req,
    output logic [`RV_XLEN-1:0] rdata
);

    logic [31:0] mem [`RV_MEM_WORDS];

    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.be[b])
                        mem[req.addr][b*8 +: 8] <= req.wdata[b*8 +: 8];
                end
            end
            rdata <= mem[req.addr]; // old word on a write
        end
    end

endmodule

// ==== hw/cpu_top.sv ====
module cpu_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             run,
    input  rv_pkg::mem_req_t host_req,
    output logic             host_gnt,
    output logic [31:0]      host_rdata,
    output logic             halted
);

    rv_pkg::mem_req_t core_req, ram_req;
    logic             core_gnt;
    logic [31:0]      core_rdata, ram_rdata;

    cpu_core u_core (
        .clk(clk), .reset(reset), .run(run),
        .mem_req(core_req), .mem_gnt(core_gnt), .mem_rdata(core_rdata),
        .halted(halted)
    );

    mem_arbiter u_arb (
        .clk(clk), .reset(reset),
        .core_req(core_req), .core_gnt(core_gnt), .core_rdata(core_rdata),
        .host_req(host_req), .host_gnt(host_gnt), .host_rdata(host_rdata),
        .ram_req(ram_req), .ram_rdata(ram_rdata)
    );

    unified_ram u_ram (.clk(clk), .req(ram_req), .rdata(ram_rdata));

endmodule

// ==== dv/cpu_tb.sv ====
`include "rv_params.svh"

module cpu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [6:0]  OP_IMM = 7'b0010011;
    localparam logic [6:0]  LOAD   = 7'b0000011;
    localparam logic [6:0]  LUI    = 7'b0110111;
    localparam logic [6:0]  AUIPC  = 7'b0010111;
    localparam logic [6:0]  JALR   = 7'b1100111;
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    // budget per test is 128 executed instructions and 64 host words
    localparam int NUM_TESTS      = 6;
    localparam int MAX_INSTR      = 128;
    localparam int LOAD_WORDS     = 64;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (MAX_INSTR * 3 + LOAD_WORDS + 20) * 2;

    logic             clk;
    logic             reset;
    logic             run;
    rv_pkg::mem_req_t host_req;
    logic             host_gnt;
    logic [31:0]      host_rdata;
    logic             halted;

    integer      seed = 32'h81bf_b057;
    int          errors;
    int          checks;
    int          cycle_count;
    string       test_name;
    string       phase;
    logic [31:0] prog [$];

    cpu_top UUT (
        .clk(clk), .reset(reset), .run(run),
        .host_req(host_req), .host_gnt(host_gnt), .host_rdata(host_rdata),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles in %s, %s", cycle_count, test_name, phase);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // lw/sw with x0 as base
    function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [11:0] off);
        return i_type(off, 5'd0, 3'd2, rd, LOAD);
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [11:0] off);
        return s_type(off, rs2, 5'd0, 3'd2);
    endfunction

    // RV32I result rules by funct3 and alt (funct7 bit 5)
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] act,
                              input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, act, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, act, exp);
        end
    endtask

    task automatic check_req(input string name, input rv_pkg::mem_req_t act,
                             input rv_pkg::mem_req_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, act, exp);
        end
    endtask

    // one host transfer with the request held until granted
    task automatic host_access(input logic wr, input logic [31:0] byte_addr,
                               input logic [31:0] data, output logic [31:0] rdata);
        rv_pkg::mem_req_t req;
        req       = '0;
        req.valid = 1'b1;
        req.write = wr;
        req.addr  = byte_addr[`RV_MEM_AW+1:2];
        req.be    = wr ? 4'hf : 4'h0;
        req.wdata = data;
        phase = "waiting for host grant";
        @(posedge clk);
        host_req <= req;
        @(negedge clk);
        while (!host_gnt)
            @(negedge clk);
        check_req("ram_req", UUT.ram_req, req); // arbiter forwards the host request
        @(posedge clk);
        host_req <= '0;
        @(negedge clk);
        rdata = host_rdata;
        check_flag("host_gnt without request", host_gnt, 1'b0);
        phase = "idle";
    endtask

    task automatic host_write(input logic [31:0] byte_addr, input logic [31:0] data);
        logic [31:0] unused;
        host_access(1'b1, byte_addr, data, unused);
    endtask

    task automatic host_read(input logic [31:0] byte_addr, output logic [31:0] data);
        host_access(1'b0, byte_addr, 32'h0, data);
    endtask

    task automatic check_mem(input string name, input logic [31:0] byte_addr,
                             input logic [31:0] exp);
        logic [31:0] act;
        host_read(byte_addr, act);
        check_word(name, act, exp);
    endtask

    task automatic load_program;
        foreach (prog[i])
            host_write(i * 4, prog[i]);
    endtask

    task automatic start_cpu;
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        run   <= 1'b1;
    endtask

    task automatic wait_halted;
        phase = "waiting for halted";
        @(negedge clk);
        while (!halted)
            @(negedge clk);
        @(posedge clk);
        run <= 1'b0;
        phase = "idle";
    endtask

    task automatic alu_ops;
        logic [31:0] a, b;
        logic [31:0] exp_q [$];
        logic [11:0] imm12;
        logic [19:0] up;
        logic [2:0]  f3;
        logic        alt;
        test_name = "alu ops";
        prog = {};
        a = $random(seed);
        b = $random(seed);
        host_write(32'h400, a);
        host_write(32'h404, b);
        prog.push_back(load_word(5'd1, 12'h400));
        prog.push_back(load_word(5'd2, 12'h404));
        for (int k = 0; k < 10; k++) begin // the 8 funct3 codes then sub and sra
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
            alt = k >= 8;
            prog.push_back(r_type(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
            prog.push_back(store_word(5'd3, 12'h500 + 12'(exp_q.size() * 4)));
            exp_q.push_back(alu_model(f3, alt, a, b));
        end
        for (int k = 0; k < 9; k++) begin
            f3    = (k < 8) ? 3'(k) : 3'd5;
            alt   = k == 8;
            imm12 = $random(seed);
            if (f3 == 3'd1 || f3 == 3'd5)
                imm12 = {alt ? 7'h20 : 7'h00, imm12[4:0]}; // shamt form
            prog.push_back(i_type(imm12, 5'd1, f3, 5'd3, OP_IMM));
            prog.push_back(store_word(5'd3, 12'h500 + 12'(exp_q.size() * 4)));
            exp_q.push_back(alu_model(f3, alt, a, {{20{imm12[11]}}, imm12}));
        end
        up = $random(seed);
        prog.push_back(u_type(up, 5'd3, LUI));
        prog.push_back(store_word(5'd3, 12'h500 + 12'(exp_q.size() * 4)));
        exp_q.push_back({up, 12'h000});
        prog.push_back(EBREAK);
        load_program();
        start_cpu();
        wait_halted();
        foreach (exp_q[i])
            check_mem($sformatf("alu result %0d", i), 32'h500 + i * 4, exp_q[i]);
    endtask

    task automatic loads_and_stores;
        logic [31:0] w0, w1, w2, w3, exp;
        logic [1:0]  lane;
        logic [7:0]  byte_val;
        test_name = "loads and stores";
        prog = {};
        w0 = $random(seed);
        w1 = $random(seed);
        w2 = $random(seed);
        w3 = $random(seed);
        w2[7]  = 1'b1; // one negative and one positive byte at least
        w2[15] = 1'b0;
        lane = $random(seed);
        host_write(32'h400, w0);
        host_write(32'h404, w1);
        host_write(32'h408, w2);
        host_write(32'h40c, w3);
        prog.push_back(load_word(5'd1, 12'h400));
        prog.push_back(store_word(5'd1, 12'h500));
        prog.push_back(load_word(5'd2, 12'h40c));
        prog.push_back(s_type(12'h404 + 12'(lane), 5'd2, 5'd0, 3'd0)); // sb
        for (int l = 0; l < 4; l++) begin
            prog.push_back(i_type(12'h408 + 12'(l), 5'd0, 3'd0, 5'd3, LOAD)); // lb
            prog.push_back(store_word(5'd3, 12'h504 + 12'(l * 4)));
        end
        prog.push_back(EBREAK);
        load_program();
        start_cpu();
        wait_halted();
        check_mem("sw/lw word", 32'h500, w0);
        exp = w1;
        exp[lane*8 +: 8] = w3[7:0];
        check_mem("sb lane", 32'h404, exp);
        for (int l = 0; l < 4; l++) begin
            byte_val = w2[l*8 +: 8];
            check_mem($sformatf("lb lane %0d", l), 32'h504 + l * 4, {{24{byte_val[7]}}, byte_val});
        end
    endtask

    task automatic branches;
        logic [31:0] p, n, marker, va, vb;
        logic [2:0]  kinds [6];
        logic [4:0]  ra [12];
        logic [4:0]  rb [12];
        test_name = "branches";
        prog = {};
        kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        // x1 and x2 hold p and x3 holds n
        // per kind a taken pair comes first and a not taken pair second
        ra = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd3, 5'd1, 5'd1, 5'd3, 5'd1, 5'd3, 5'd3, 5'd1};
        rb = '{5'd2, 5'd3, 5'd3, 5'd2, 5'd1, 5'd3, 5'd3, 5'd1, 5'd3, 5'd1, 5'd1, 5'd3};
        p      = $random(seed) & 32'h7fff_ffff;
        n      = $random(seed) | 32'h8000_0000;
        marker = $random(seed) | 32'h1;
        host_write(32'h400, p);
        host_write(32'h404, n);
        host_write(32'h408, marker);
        for (int k = 0; k < 12; k++)
            host_write(32'h500 + k * 4, 32'h0);
        prog.push_back(load_word(5'd1, 12'h400));
        prog.push_back(load_word(5'd2, 12'h400));
        prog.push_back(load_word(5'd3, 12'h404));
        prog.push_back(load_word(5'd4, 12'h408));
        for (int k = 0; k < 12; k++) begin
            prog.push_back(b_type(13'd8, rb[k], ra[k], kinds[k/2])); // skips the store
            prog.push_back(store_word(5'd4, 12'h500 + 12'(k * 4)));
        end
        prog.push_back(EBREAK);
        load_program();
        start_cpu();
        wait_halted();
        for (int k = 0; k < 12; k++) begin
            va = (ra[k] == 5'd3) ? n : p;
            vb = (rb[k] == 5'd3) ? n : p;
            check_mem($sformatf("branch %0d funct3 %0d", k, kinds[k/2]), 32'h500 + k * 4,
                      branch_model(kinds[k/2], va, vb) ? 32'h0 : marker);
        end
    endtask

    task automatic jumps;
        logic [31:0] m1, m2;
        test_name = "jumps";
        prog = {};
        m1 = $random(seed) | 32'h1;
        m2 = $random(seed) | 32'h1;
        host_write(32'h508, m1);
        host_write(32'h50c, m2);
        prog.push_back(j_type(21'd8, 5'd1));                        // jal x1 from 0 to 8
        prog.push_back(store_word(5'd0, 12'h508));                  // skipped
        prog.push_back(store_word(5'd1, 12'h500));                  // at 8
        prog.push_back(i_type(12'd25, 5'd0, 3'd0, 5'd2, OP_IMM));   // at 12
        prog.push_back(i_type(12'd4, 5'd2, 3'd0, 5'd3, JALR));      // jalr at 16 to 29 then 28
        prog.push_back(store_word(5'd0, 12'h50c));                  // skipped
        prog.push_back(store_word(5'd0, 12'h50c));                  // skipped
        prog.push_back(store_word(5'd3, 12'h504));                  // at 28
        prog.push_back(EBREAK);
        load_program();
        start_cpu();
        wait_halted();
        check_mem("jal link", 32'h500, 32'd0 + 32'd4);
        check_mem("jalr link", 32'h504, 32'd16 + 32'd4);
        check_mem("after jal", 32'h508, m1);
        check_mem("after jalr", 32'h50c, m2);
    endtask

    task automatic auipc_and_x0;
        logic [31:0] m;
        logic [19:0] up;
        test_name = "auipc and x0";
        prog = {};
        m  = $random(seed) | 32'h1;
        up = $random(seed);
        host_write(32'h500, m);
        prog.push_back(i_type(12'h123, 5'd0, 3'd0, 5'd0, OP_IMM));
        prog.push_back(u_type(up, 5'd0, LUI));
        prog.push_back(store_word(5'd0, 12'h500));
        prog.push_back(u_type(up, 5'd2, AUIPC)); // at pc 12
        prog.push_back(store_word(5'd2, 12'h504));
        prog.push_back(EBREAK);
        load_program();
        start_cpu();
        wait_halted();
        check_mem("x0", 32'h500, 32'h0);
        check_mem("auipc", 32'h504, 32'd12 + {up, 12'h000});
    endtask

    task automatic shared_port_polls;
        logic [31:0] d, act;
        logic [11:0] n_iter;
        test_name = "shared port polls";
        prog = {};
        d      = $random(seed);
        n_iter = 12'd40 + 12'($random(seed) & 15);
        host_write(32'h404, d);
        host_write(32'h500, 32'hffff_ffff);
        prog.push_back(i_type(n_iter, 5'd0, 3'd0, 5'd1, OP_IMM));
        prog.push_back(i_type(12'hfff, 5'd1, 3'd0, 5'd1, OP_IMM)); // loop body decrements x1
        prog.push_back(b_type(13'h1ffc, 5'd0, 5'd1, 3'd1));        // bne back to loop
        prog.push_back(store_word(5'd1, 12'h500));
        prog.push_back(EBREAK);
        load_program();
        start_cpu();
        for (int i = 0; i < 4; i++) begin
            host_read(32'h404, act);
            check_word($sformatf("poll %0d", i), act, d);
        end
        check_flag("halted during polls", halted, 1'b0);
        wait_halted();
        check_mem("loop counter", 32'h500, 32'h0);
    endtask

    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        host_req  = '0;
        errors    = 0;
        checks    = 0;
        test_name = "reset";
        phase     = "idle";
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        alu_ops();
        loads_and_stores();
        branches();
        jumps();
        auipc_and_x0();
        shared_port_polls();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
hw/rv_pkg.sv
hw/inst_decoder.sv
hw/alu.sv
hw/reg_file.sv
hw/cpu_core.sv
hw/mem_arbiter.sv
hw/unified_ram.sv
hw/cpu_top.sv
dv/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and pass only if the pass message shows up
verilator --binary -Wno-fatal -f tb.f --top-module cpu_tb -o cpu_tb_sim \
    && ./obj_dir/cpu_tb_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "run_sim: PASS" \
    || { echo "run_sim: FAIL"; exit 1; }
